// ==== include/rob_defs.svh ====
// Reorder buffer size, dispatch and commit widths, and field width macros
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// ====================
// Buffer geometry
// ====================

// Number of reorder buffer entries, kept a power of two
`define RENTRIES 8
// Width of an entry index, log2 of the entry count
`define ROB_ID_BITS 3

// Instructions accepted by dispatch in one cycle
`define DISP_WIDTH 2
// Entries retired by commit in one cycle at most
`define CMT_WIDTH 4
// Width of a commit count, enough to hold 0 up to CMT_WIDTH
`define CMT_CNT_BITS 3

// ====================
// Payload fields
// ====================

// Architectural destination register number
`define DEST_BITS 5
// Result value carried from writeback to commit
`define VALUE_BITS 32

`endif

// ==== verilog/robPkg.sv ====
// Reorder buffer vector typedefs and the entry state enum
`default_nettype none

`include "rob_defs.svh"

package robPkg;

	// ====================
	// Vector types
	// ====================

	// Index of a reorder buffer entry, used for heads, the tail and writeback ids
	typedef logic [`ROB_ID_BITS-1:0] SrcId;

	// Number of entries retired in one cycle, also the amount the heads advance
	typedef logic [`CMT_CNT_BITS-1:0] CommitCount;

	// Architectural destination register of an instruction
	typedef logic [`DEST_BITS-1:0] DestReg;

	// Result produced by an execution unit
	typedef logic [`VALUE_BITS-1:0] ResultValue;

	// ====================
	// Entry state
	// ====================

	// An entry moves empty -> issued at allocation, issued -> done at writeback,
	// and done -> empty when commit retires it
	typedef enum logic [1:0] {
		entryEmpty  = 2'd0,
		entryIssued = 2'd1,
		entryDone   = 2'd2
	} EntryState;

endpackage

`default_nettype wire

// ==== verilog/headPointers.sv ====
// Rotating head index set for the reorder buffer, advanced by the commit amount
`timescale 1ns/100ps
`default_nettype none

`include "rob_defs.svh"

module headPointers #(
	parameter int RENTRIES = `RENTRIES
) (
	input  logic              clk,
	input  logic              rst,
	input  robPkg::CommitCount amt,
	output robPkg::SrcId       heads [0:RENTRIES-1]
);
	import robPkg::*;

	// Head i always names the entry i places behind the oldest one, so
	// the first few heads give the commit window in program order

	// Every head moves by the same amount each cycle, which keeps the set
	// rotating as one unit around the buffer
	always_ff @(posedge clk) begin
		if (rst) begin
			// Oldest entry starts at 0, the rest follow in order
			for (int i = 0; i < RENTRIES; i++) begin
				heads[i] <= SrcId'(i);
			end
		end else begin
			// Wrap around the end of the buffer
			for (int i = 0; i < RENTRIES; i++) begin
				heads[i] <= SrcId'((heads[i] + amt) % RENTRIES);
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/dispatchUnit.sv ====
// Dispatch unit with tail pointer, free entry count, full flag and slot allocation
`timescale 1ns/100ps
`default_nettype none

`include "rob_defs.svh"

module dispatchUnit (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [`DISP_WIDTH-1:0]       dispVal,
	input  robPkg::DestReg               dispDest [0:`DISP_WIDTH-1],
	input  robPkg::CommitCount           amt,
	output robPkg::SrcId                 dispId [0:`DISP_WIDTH-1],
	output logic                         full,
	output logic [`DISP_WIDTH-1:0]       wrEn,
	output robPkg::SrcId                 wrId [0:`DISP_WIDTH-1],
	output robPkg::DestReg               wrDest [0:`DISP_WIDTH-1]
);
	import robPkg::*;

	// Next entry to hand out, one past the youngest allocated entry
	SrcId tailPtr;

	// Free entries, needs one more bit than an index to hold RENTRIES
	logic [`ROB_ID_BITS:0] freeCnt;

	// Slots actually taken this cycle
	logic [1:0] numAccepted;

	// ====================
	// Allocation
	// ====================

	// Fewer than a full dispatch group free means the producer has to wait
	// The flag comes straight from a register so it is stable for the cycle
	assign full = (freeCnt < `DISP_WIDTH);

	// Valid slots are packed from slot 0, so slot 1 only skips ahead of the
	// tail when slot 0 is using the tail itself
	always_comb begin
		dispId[0] = tailPtr;
		if (dispVal[0]) begin
			dispId[1] = SrcId'((tailPtr + 1'b1) % `RENTRIES);
		end else begin
			dispId[1] = tailPtr;
		end
	end

	// Write requests to the buffer, suppressed entirely while full
	always_comb begin
		for (int s = 0; s < `DISP_WIDTH; s++) begin
			wrEn[s]   = dispVal[s] & ~full;
			wrId[s]   = dispId[s];
			wrDest[s] = dispDest[s];
		end
	end

	// Count of accepted slots drives both the tail and the free count
	assign numAccepted = {1'b0, wrEn[0]} + {1'b0, wrEn[1]};

	// ====================
	// Tail and free count
	// ====================

	// Retired entries come back and new ones go out in the same cycle
	// An entry being retired is never the one allocated, since the count
	// only includes it from the next cycle on
	always_ff @(posedge clk) begin
		if (rst) begin
			tailPtr <= '0;
			freeCnt <= (`ROB_ID_BITS+1)'(`RENTRIES);
		end else begin
			// Tail moves only by what was really accepted
			tailPtr <= SrcId'((tailPtr + numAccepted) % `RENTRIES);
			// Never exceeds RENTRIES because amt counts allocated entries only
			freeCnt <= freeCnt + amt - numAccepted;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/reorderBuffer.sv ====
// Reorder buffer entry storage with allocation, writeback, retirement and head read-out
`timescale 1ns/100ps
`default_nettype none

`include "rob_defs.svh"

module reorderBuffer (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`DISP_WIDTH-1:0] wrEn,
	input  robPkg::SrcId           wrId [0:`DISP_WIDTH-1],
	input  robPkg::DestReg         wrDest [0:`DISP_WIDTH-1],
	input  logic                   wbVal,
	input  robPkg::SrcId           wbId,
	input  robPkg::ResultValue     wbValue,
	input  robPkg::SrcId           heads [0:`RENTRIES-1],
	input  robPkg::CommitCount     amt,
	output robPkg::EntryState      headState [0:`CMT_WIDTH-1],
	output robPkg::DestReg         headDest [0:`CMT_WIDTH-1],
	output robPkg::ResultValue     headValue [0:`CMT_WIDTH-1]
);
	import robPkg::*;

	// ====================
	// Entry storage
	// ====================

	// Per entry lifecycle state
	EntryState  entState [0:`RENTRIES-1];

	// Payload written at allocation and at writeback
	DestReg     entDest  [0:`RENTRIES-1];
	ResultValue entValue [0:`RENTRIES-1];

	// Writeback is only honoured for an entry still waiting on its result
	logic wbHit;

	assign wbHit = wbVal && (entState[wbId] == entryIssued);

	// ====================
	// Update
	// ====================

	// The three sources of change touch disjoint entries in normal operation
	// Allocation only targets empty entries, writeback only issued ones and
	// retirement only done ones, so the order below matters only for
	// misbehaving inputs and then retirement wins
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `RENTRIES; i++) begin
				entState[i] <= entryEmpty;
			end
		end else begin
			// New instructions from dispatch
			for (int s = 0; s < `DISP_WIDTH; s++) begin
				if (wrEn[s]) begin
					entState[wrId[s]] <= entryIssued;
					entDest[wrId[s]]  <= wrDest[s];
				end
			end

			// Results arriving out of order from the execution side
			if (wbHit) begin
				entState[wbId] <= entryDone;
				entValue[wbId] <= wbValue;
			end

			// Free the oldest amt entries that commit retires this cycle
			for (int c = 0; c < `CMT_WIDTH; c++) begin
				if (c < amt) begin
					entState[heads[c]] <= entryEmpty;
				end
			end
		end
	end

	// ====================
	// Head window
	// ====================

	// The first CMT_WIDTH heads give commit its look at the oldest entries
	always_comb begin
		for (int c = 0; c < `CMT_WIDTH; c++) begin
			headState[c] = entState[heads[c]];
			headDest[c]  = entDest[heads[c]];
			headValue[c] = entValue[heads[c]];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/commitUnit.sv ====
// Commit unit finding the done run at the head and registering the retirement outputs
`timescale 1ns/100ps
`default_nettype none

`include "rob_defs.svh"

module commitUnit (
	input  logic                  clk,
	input  logic                  rst,
	input  robPkg::EntryState     headState [0:`CMT_WIDTH-1],
	input  robPkg::DestReg        headDest [0:`CMT_WIDTH-1],
	input  robPkg::ResultValue    headValue [0:`CMT_WIDTH-1],
	output robPkg::CommitCount    amt,
	output logic [`CMT_WIDTH-1:0] cmtVal,
	output robPkg::DestReg        cmtDest [0:`CMT_WIDTH-1],
	output robPkg::ResultValue    cmtValue [0:`CMT_WIDTH-1]
);
	import robPkg::*;

	// ====================
	// Retire amount
	// ====================

	// Retirement must stay in program order, so the scan stops at the first
	// head that is not done even if younger entries behind it are
	// The result feeds the heads, the buffer and the free count this cycle
	always_comb begin
		logic runOpen;

		amt     = '0;
		runOpen = 1'b1;
		for (int c = 0; c < `CMT_WIDTH; c++) begin
			if (runOpen && (headState[c] == entryDone)) begin
				amt = amt + 1'b1;
			end else begin
				// Anything past a gap has to wait for a later cycle
				runOpen = 1'b0;
			end
		end
	end

	// ====================
	// Retirement outputs
	// ====================

	// Valid bits are a thermometer of amt, always packed from bit 0
	// They pulse for one cycle per retirement and never stall
	always_ff @(posedge clk) begin
		if (rst) begin
			cmtVal <= '0;
		end else begin
			for (int c = 0; c < `CMT_WIDTH; c++) begin
				cmtVal[c] <= (c < amt);
			end
		end
	end

	// Payload follows the head window every cycle, qualified by cmtVal
	// Lanes beyond amt carry whatever the younger heads held
	always_ff @(posedge clk) begin
		for (int c = 0; c < `CMT_WIDTH; c++) begin
			cmtDest[c]  <= headDest[c];
			cmtValue[c] <= headValue[c];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/robTop.sv ====
// Retirement top level joining dispatch, reorder buffer, head pointers and commit
`timescale 1ns/100ps
`default_nettype none

`include "rob_defs.svh"

module robTop (
	input  logic                   clk,
	input  logic                   rst,
	// Dispatch side
	input  logic [`DISP_WIDTH-1:0] dispVal,
	input  robPkg::DestReg         dispDest [0:`DISP_WIDTH-1],
	output robPkg::SrcId           dispId [0:`DISP_WIDTH-1],
	output logic                   full,
	// Writeback from the execution units
	input  logic                   wbVal,
	input  robPkg::SrcId           wbId,
	input  robPkg::ResultValue     wbValue,
	// Retirement stream
	output logic [`CMT_WIDTH-1:0]  cmtVal,
	output robPkg::DestReg         cmtDest [0:`CMT_WIDTH-1],
	output robPkg::ResultValue     cmtValue [0:`CMT_WIDTH-1]
);
	import robPkg::*;

	// ====================
	// Internal nets
	// ====================

	// Allocation writes from dispatch into the buffer
	logic [`DISP_WIDTH-1:0] wrEn;
	SrcId                   wrId [0:`DISP_WIDTH-1];
	DestReg                 wrDest [0:`DISP_WIDTH-1];

	// Rotating head indices and the per cycle retire amount
	SrcId       heads [0:`RENTRIES-1];
	CommitCount amt;

	// Head window presented to commit
	EntryState  headState [0:`CMT_WIDTH-1];
	DestReg     headDest [0:`CMT_WIDTH-1];
	ResultValue headValue [0:`CMT_WIDTH-1];

	// ====================
	// Blocks
	// ====================

	// Tail side, hands out entries and tracks how many are free
	dispatchUnit dispatch0 (
		.clk      (clk),
		.rst      (rst),
		.dispVal  (dispVal),
		.dispDest (dispDest),
		.amt      (amt),
		.dispId   (dispId),
		.full     (full),
		.wrEn     (wrEn),
		.wrId     (wrId),
		.wrDest   (wrDest)
	);

	// Entry storage
	reorderBuffer rob0 (
		.clk       (clk),
		.rst       (rst),
		.wrEn      (wrEn),
		.wrId      (wrId),
		.wrDest    (wrDest),
		.wbVal     (wbVal),
		.wbId      (wbId),
		.wbValue   (wbValue),
		.heads     (heads),
		.amt       (amt),
		.headState (headState),
		.headDest  (headDest),
		.headValue (headValue)
	);

	// Head side, moves with every retirement
	headPointers heads0 (
		.clk   (clk),
		.rst   (rst),
		.amt   (amt),
		.heads (heads)
	);

	// In order retirement of the done run at the head
	commitUnit commit0 (
		.clk       (clk),
		.rst       (rst),
		.headState (headState),
		.headDest  (headDest),
		.headValue (headValue),
		.amt       (amt),
		.cmtVal    (cmtVal),
		.cmtDest   (cmtDest),
		.cmtValue  (cmtValue)
	);

endmodule

`default_nettype wire

// ==== sim/robTb.sv ====
// Testbench for the retirement top level with a reference queue model and commit checker
`timescale 1ns/100ps
`default_nettype none

`include "rob_defs.svh"

module robTb;
	import robPkg::*;

	// ====================
	// Test constants
	// ====================

	// Instructions pushed through the buffer in the random traffic test
	localparam int NUM_RANDOM = 400;
	// Instructions of all directed tests together plus the random ones
	localparam int TOTAL_INSTR = 2 + 6 + 8 + 8 + NUM_RANDOM;
	// Each instruction needs a dispatch, a writeback and a retirement slot
	localparam int CYCLE_LIMIT = 4 * TOTAL_INSTR + 200;
	localparam int MAX_SEQ = 1024;

	logic clk;
	logic rst;
	logic [`DISP_WIDTH-1:0] dispVal;
	DestReg dispDest [0:`DISP_WIDTH-1];
	SrcId dispId [0:`DISP_WIDTH-1];
	logic full;
	logic wbVal;
	SrcId wbId;
	ResultValue wbValue;
	logic [`CMT_WIDTH-1:0] cmtVal;
	DestReg cmtDest [0:`CMT_WIDTH-1];
	ResultValue cmtValue [0:`CMT_WIDTH-1];

	// Reference model indexed by program order sequence number
	SrcId seqId [0:MAX_SEQ-1];
	DestReg seqDest [0:MAX_SEQ-1];
	ResultValue seqValue [0:MAX_SEQ-1];
	logic seqDone [0:MAX_SEQ-1];
	int retireQ [$];
	int pending [$];
	SrcId modelTail;
	int seqCount;
	int lastAccepted;
	SrcId seenId [0:`DISP_WIDTH-1];

	// Bookkeeping
	int testErrors;
	int totalErrors;
	int testCount;
	int failedTests;
	int retiredCnt;
	int cycleCnt;
	logic wideSeen;

	robTop dut0 (
		.clk      (clk),
		.rst      (rst),
		.dispVal  (dispVal),
		.dispDest (dispDest),
		.dispId   (dispId),
		.full     (full),
		.wbVal    (wbVal),
		.wbId     (wbId),
		.wbValue  (wbValue),
		.cmtVal   (cmtVal),
		.cmtDest  (cmtDest),
		.cmtValue (cmtValue)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ====================
	// Reporting
	// ====================

	task automatic reportMismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("[FAIL] %s expected 0x%0h got 0x%0h", name, expected, actual);
		testErrors++;
	endtask

	task automatic reportProblem(input string msg);
		$display("Error: %s", msg);
		testErrors++;
	endtask

	task automatic finishTest(input string name);
		if (testErrors == 0) begin
			$display("Test %s: ok", name);
		end else begin
			$display("Test %s: %0d errors", name, testErrors);
			failedTests++;
		end
		totalErrors += testErrors;
		testErrors = 0;
		testCount++;
	endtask

	// ====================
	// Model and stimulus
	// ====================

	// Expected retirement at position pos of the program order queue with dest above value
	function automatic logic [`DEST_BITS+`VALUE_BITS-1:0] expectedRetire(input int pos);
		int seq;
		seq = retireQ[pos];
		return {seqDest[seq], seqValue[seq]};
	endfunction

	// Random instruction still waiting for its result or -1 when there is none
	function automatic int pickPending(input int skip);
		int cand [$];
		foreach (pending[k]) begin
			if (pending[k] != skip) begin
				cand.push_back(pending[k]);
			end
		end
		if (cand.size() == 0) begin
			return -1;
		end
		return cand[$urandom % cand.size()];
	endfunction

	// One clock cycle of dispatch and optional writeback of sequence wbSeq
	// Acceptance is judged on the full level sampled just before the edge
	task automatic runCycle(input logic [1:0] dv, input int wbSeq);
		@(negedge clk);
		dispVal = dv;
		dispDest[0] = DestReg'($urandom);
		dispDest[1] = DestReg'($urandom);
		if (wbSeq >= 0) begin
			wbVal = 1'b1;
			wbId = seqId[wbSeq];
			wbValue = ResultValue'($urandom);
			seqValue[wbSeq] = wbValue;
			seqDone[wbSeq] = 1'b1;
			foreach (pending[k]) begin
				if (pending[k] == wbSeq) begin
					pending.delete(k);
					break;
				end
			end
		end else begin
			wbVal = 1'b0;
		end
		@(posedge clk);
		lastAccepted = 0;
		if (!full) begin
			for (int s = 0; s < `DISP_WIDTH; s++) begin
				if (dv[s]) begin
					// Valid slots take consecutive entries from the tail
					seenId[s] = dispId[s];
					assert (dispId[s] == modelTail)
						else reportMismatch($sformatf("dispId[%0d]", s), modelTail, dispId[s]);
					seqId[seqCount] = modelTail;
					seqDest[seqCount] = dispDest[s];
					seqDone[seqCount] = 1'b0;
					retireQ.push_back(seqCount);
					pending.push_back(seqCount);
					seqCount++;
					modelTail = SrcId'((int'(modelTail) + 1) % `RENTRIES);
					lastAccepted++;
				end
			end
		end
	endtask

	// Writes back everything outstanding, then waits for the queue to empty
	task automatic drainAll();
		while (pending.size() > 0) begin
			runCycle(2'b00, pickPending(-1));
		end
		while (retireQ.size() > 0) begin
			runCycle(2'b00, -1);
		end
	endtask

	// ====================
	// Commit checker
	// ====================

	// Lanes must be packed from bit 0 and match the oldest model entries
	always @(posedge clk) begin : commitCheck
		logic gap;
		logic [`DEST_BITS+`VALUE_BITS-1:0] exp;
		int seq;
		if (!rst) begin
			gap = 1'b0;
			if (cmtVal == {`CMT_WIDTH{1'b1}}) begin
				wideSeen = 1'b1;
			end
			for (int c = 0; c < `CMT_WIDTH; c++) begin
				if (cmtVal[c]) begin
					assert (!gap) else reportProblem("commit valid bit set after a gap");
					assert (retireQ.size() > 0)
						else reportProblem("retirement reported with no instruction outstanding");
					if (retireQ.size() > 0) begin
						exp = expectedRetire(0);
						seq = retireQ.pop_front();
						assert (seqDone[seq])
							else reportProblem($sformatf("instruction %0d retired before writeback", seq));
						assert (cmtDest[c] == exp[`DEST_BITS+`VALUE_BITS-1:`VALUE_BITS])
							else reportMismatch($sformatf("cmtDest[%0d]", c),
								exp[`DEST_BITS+`VALUE_BITS-1:`VALUE_BITS], cmtDest[c]);
						assert (cmtValue[c] == exp[`VALUE_BITS-1:0])
							else reportMismatch($sformatf("cmtValue[%0d]", c),
								exp[`VALUE_BITS-1:0], cmtValue[c]);
						retiredCnt++;
					end
				end else begin
					gap = 1'b1;
				end
			end
		end
	end

	// A stalled commit stream ends the run here
	always @(posedge clk) begin
		cycleCnt++;
		if (cycleCnt >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ====================
	// Test sequence
	// ====================

	initial begin
		int seedDummy;
		int count;
		int oldestSeq;
		int startSeq;
		logic [1:0] dv;

		seedDummy = $urandom(32'h95b0a5b0);
		rst = 1'b1;
		dispVal = '0;
		dispDest[0] = '0;
		dispDest[1] = '0;
		wbVal = 1'b0;
		wbId = '0;
		wbValue = '0;
		modelTail = '0;
		seqCount = 0;
		lastAccepted = 0;
		testErrors = 0;
		totalErrors = 0;
		testCount = 0;
		failedTests = 0;
		retiredCnt = 0;
		cycleCnt = 0;
		wideSeen = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Reset values, then the first pair lands on entries 0 and 1
		@(posedge clk);
		assert (!full) else reportMismatch("full", 0, full);
		assert (cmtVal == '0) else reportMismatch("cmtVal", 0, cmtVal);
		runCycle(2'b11, -1);
		assert (lastAccepted == 2) else reportProblem("first dispatch pair was not accepted");
		assert (seenId[0] == 0) else reportMismatch("dispId[0]", 0, seenId[0]);
		assert (seenId[1] == 1) else reportMismatch("dispId[1]", 1, seenId[1]);
		drainAll();
		finishTest("reset");

		// Shuffled writeback of a batch of six
		repeat (3) runCycle(2'b11, -1);
		drainAll();
		finishTest("out of order writeback");

		// Oldest entry blocks seven done entries behind it
		wideSeen = 1'b0;
		oldestSeq = seqCount;
		repeat (4) runCycle(2'b11, -1);
		repeat (7) begin
			runCycle(2'b00, pickPending(oldestSeq));
			assert (cmtVal == '0) else reportMismatch("cmtVal", 0, cmtVal);
		end
		runCycle(2'b00, oldestSeq);
		runCycle(2'b00, -1);
		assert (cmtVal == '0) else reportMismatch("cmtVal", 0, cmtVal);
		runCycle(2'b00, -1);
		assert (cmtVal == 4'hf) else reportMismatch("cmtVal", 4'hf, cmtVal);
		drainAll();
		assert (wideSeen) else reportProblem("no cycle retired four entries at once");
		finishTest("wide retirement");

		// Fill without writeback until full, then hold the pair
		count = 0;
		do begin
			runCycle(2'b11, -1);
			count += lastAccepted;
		end while (lastAccepted > 0 && count < 2 * `RENTRIES);
		assert (count == `RENTRIES) else reportMismatch("accepted count", `RENTRIES, count);
		repeat (6) begin
			runCycle(2'b11, -1);
			assert (full) else reportMismatch("full", 1, full);
			assert (dispId[0] == modelTail) else reportMismatch("dispId[0]", modelTail, dispId[0]);
			assert (cmtVal == '0) else reportMismatch("cmtVal", 0, cmtVal);
		end
		drainAll();
		finishTest("full back-pressure");

		// Random traffic where a refused group is offered again
		startSeq = seqCount;
		dv = 2'b00;
		while (seqCount - startSeq < NUM_RANDOM) begin
			if (dv == 2'b00 || lastAccepted > 0) begin
				dv = 2'($urandom);
			end
			runCycle(dv, ($urandom % 4 != 0) ? pickPending(-1) : -1);
		end
		drainAll();
		finishTest("random wraparound");

		@(negedge clk);
		totalErrors += testErrors;
		$display("%0d tests, %0d failed, %0d errors, %0d of %0d instructions retired",
			testCount, failedTests, totalErrors, retiredCnt, seqCount);
		if (totalErrors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
verilog/robPkg.sv
verilog/headPointers.sv
verilog/dispatchUnit.sv
verilog/reorderBuffer.sv
verilog/commitUnit.sv
verilog/robTop.sv
sim/robTb.sv
